// ==== flist.f ====
+incdir+sim
hdl/fetch_pkg.sv
hdl/inst_sram.sv
hdl/fetch_stage.sv
hdl/fetch_buffer.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
sim/tb_fetch.sv

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk,
  input  logic               resetn,
  input  logic               flush,
  input  fetch_pkg::fs2ds_t  in_item,
  input  logic               in_valid,
  output logic               allowin,
  output fetch_pkg::br_bus_t br_bus,
  output fetch_pkg::ds_out_t ds_out,
  output logic               ds_valid,
  input  logic               es_allowin
);
  import fetch_pkg::*;

  fs2ds_t      item_q;
  logic        valid_q;
  logic        taken_q;
  logic        capture;
  logic        is_bl;
  logic [25:0] offs26;

  // direct jump, unless fetch already flagged the address
  function automatic logic is_jump(input fs2ds_t item);
    logic [5:0] op;
    op = item.inst.imm26_fmt.opcode;
    return ~item.exc.adef & ((op == op_b) | (op == op_bl));
  endfunction

  assign allowin = ~valid_q | es_allowin;
  assign capture = in_valid & allowin;

  always_ff @(posedge clk) begin
    if (capture) begin
      item_q <= in_item;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || flush) begin
      valid_q <= 1'b0;
      taken_q <= 1'b0;
    end else begin
      if (allowin) begin
        valid_q <= in_valid;
      end
      // one pulse per captured jump
      taken_q <= capture & is_jump(in_item);
    end
  end

  assign is_bl  = is_jump(item_q) & (item_q.inst.imm26_fmt.opcode == op_bl);
  assign offs26 = {item_q.inst.imm26_fmt.offs25_16, item_q.inst.imm26_fmt.offs15_0};

  assign br_bus.taken  = taken_q;
  assign br_bus.target = item_q.pc + {{4{offs26[25]}}, offs26, 2'b00};

  assign ds_valid         = valid_q;
  assign ds_out.pc        = item_q.pc;
  assign ds_out.inst      = item_q.inst;
  assign ds_out.exc       = item_q.exc;
  assign ds_out.is_branch = is_jump(item_q);
  assign ds_out.link      = is_bl;
  // bl writes the return address to r1
  assign ds_out.rd        = is_bl ? 5'd1 : item_q.inst.reg3_fmt.rd;

endmodule

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer (
  input  logic              clk,
  input  logic              resetn,
  input  logic              flush,
  input  fetch_pkg::fs2ds_t in_item,
  input  logic              in_valid,
  output logic              allowin,
  output fetch_pkg::fs2ds_t out_item,
  output logic              out_valid,
  input  logic              out_allowin
);
  import fetch_pkg::*;

  fs2ds_t     entries [buf_depth];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // room for at least one more item
  assign allowin = count != 2'(buf_depth);

  // nothing leaves in a flush cycle
  assign out_valid = (count != 2'd0) & ~flush;
  assign out_item  = entries[rd_ptr];

  assign push = in_valid & allowin;
  assign pop  = out_valid & out_allowin;

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_item;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || flush) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  // address and instruction word width
  localparam int addr_w = 32;

  // first sequential pc after reset lands on 0x1c000000
  localparam logic [addr_w-1:0] reset_pc = 32'h1bfffffc;

  // instruction memory geometry, indexed by word
  localparam int sram_depth = 256;
  localparam int sram_idx_w = $clog2(sram_depth);

  // fetch buffer entries
  localparam int buf_depth = 2;

  // major opcodes of the direct jumps
  localparam logic [5:0] op_b  = 6'h14;
  localparam logic [5:0] op_bl = 6'h15;

  // 26-bit offset format used by b and bl
  typedef struct packed {
    logic [5:0]  opcode;
    logic [15:0] offs15_0;
    logic [9:0]  offs25_16;
  } imm26_fmt_t;

  // three-register format
  typedef struct packed {
    logic [16:0] opcode_ext;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } reg3_fmt_t;

  typedef union packed {
    imm26_fmt_t imm26_fmt;
    reg3_fmt_t  reg3_fmt;
  } inst_word_u;

  typedef struct packed {
    logic              adef;
    logic [addr_w-1:0] bad_addr;
  } fs_exc_t;

  typedef struct packed {
    fs_exc_t           exc;
    logic [addr_w-1:0] pc;
    inst_word_u        inst;
  } fs2ds_t;

  typedef struct packed {
    logic              taken;
    logic [addr_w-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    inst_word_u        inst;
    fs_exc_t           exc;
    logic              is_branch;
    logic              link;
    logic [4:0]        rd;
  } ds_out_t;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                         clk,
  input  logic                         resetn,
  output logic                         sram_en,
  output logic [fetch_pkg::addr_w-1:0] sram_addr,
  input  logic [fetch_pkg::addr_w-1:0] sram_rdata,
  input  fetch_pkg::br_bus_t           br_bus,
  input  logic                         wb_ex,
  input  logic                         ertn_flush,
  input  logic [fetch_pkg::addr_w-1:0] csr_ex_entry,
  input  logic [fetch_pkg::addr_w-1:0] csr_ertn_entry,
  output fetch_pkg::fs2ds_t            fs_item,
  output logic                         fs_valid_out,
  input  logic                         buf_allowin
);
  import fetch_pkg::*;

  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] seq_pc;
  logic [addr_w-1:0] next_pc;
  logic              fs_valid;
  logic              fs_allowin;
  logic              redirect;

  assign seq_pc   = pc + addr_w'(4);
  assign redirect = wb_ex | ertn_flush | br_bus.taken;

  // exception first, then return, then branch
  always_comb begin
    if (wb_ex) begin
      next_pc = csr_ex_entry;
    end else if (ertn_flush) begin
      next_pc = csr_ertn_entry;
    end else if (br_bus.taken) begin
      next_pc = br_bus.target;
    end else begin
      next_pc = seq_pc;
    end
  end

  // a redirect discards the held item, so fetch can always restart
  assign fs_allowin = ~fs_valid | buf_allowin | redirect;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fs_valid <= 1'b0;
      pc       <= reset_pc;
    end else if (fs_allowin) begin
      fs_valid <= 1'b1;
      pc       <= next_pc;
    end
  end

  // next pc goes to the sram while fetch can take a new word
  assign sram_en   = resetn & fs_allowin;
  assign sram_addr = next_pc;

  // pc holds the address the current word was fetched from
  assign fs_item.exc.adef     = pc[1] | pc[0];
  assign fs_item.exc.bad_addr = pc;
  assign fs_item.pc           = pc;
  assign fs_item.inst         = sram_rdata;

  // drop the in-flight word on any redirect
  assign fs_valid_out = fs_valid & ~redirect;

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         load_en,
  input  logic [fetch_pkg::addr_w-1:0] load_addr,
  input  logic [fetch_pkg::addr_w-1:0] load_data,
  input  logic                         wb_ex,
  input  logic                         ertn_flush,
  input  logic [fetch_pkg::addr_w-1:0] csr_ex_entry,
  input  logic [fetch_pkg::addr_w-1:0] csr_ertn_entry,
  output fetch_pkg::ds_out_t           ds_out,
  output logic                         ds_valid,
  input  logic                         es_allowin
);
  import fetch_pkg::*;

  logic              sram_en;
  logic [addr_w-1:0] sram_addr;
  logic [addr_w-1:0] sram_rdata;
  br_bus_t           br_bus;
  fs2ds_t            fs_item;
  logic              fs_valid_out;
  logic              buf_allowin;
  fs2ds_t            buf_item;
  logic              buf_valid;
  logic              ds_allowin;
  logic              buf_flush;
  logic              ds_flush;

  // decode keeps its branch on a branch redirect
  assign ds_flush  = wb_ex | ertn_flush;
  assign buf_flush = ds_flush | br_bus.taken;

  inst_sram u_inst_sram (
    .clk       (clk),
    .en        (sram_en),
    .addr      (sram_addr),
    .rdata     (sram_rdata),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  fetch_stage u_fetch_stage (
    .clk            (clk),
    .resetn         (resetn),
    .sram_en        (sram_en),
    .sram_addr      (sram_addr),
    .sram_rdata     (sram_rdata),
    .br_bus         (br_bus),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .csr_ex_entry   (csr_ex_entry),
    .csr_ertn_entry (csr_ertn_entry),
    .fs_item        (fs_item),
    .fs_valid_out   (fs_valid_out),
    .buf_allowin    (buf_allowin)
  );

  fetch_buffer u_fetch_buffer (
    .clk         (clk),
    .resetn      (resetn),
    .flush       (buf_flush),
    .in_item     (fs_item),
    .in_valid    (fs_valid_out),
    .allowin     (buf_allowin),
    .out_item    (buf_item),
    .out_valid   (buf_valid),
    .out_allowin (ds_allowin)
  );

  decode_stage u_decode_stage (
    .clk        (clk),
    .resetn     (resetn),
    .flush      (ds_flush),
    .in_item    (buf_item),
    .in_valid   (buf_valid),
    .allowin    (ds_allowin),
    .br_bus     (br_bus),
    .ds_out     (ds_out),
    .ds_valid   (ds_valid),
    .es_allowin (es_allowin)
  );

endmodule

// ==== hdl/inst_sram.sv ====
`timescale 1ns/1ps

module inst_sram (
  input  logic                         clk,
  input  logic                         en,
  input  logic [fetch_pkg::addr_w-1:0] addr,
  output logic [fetch_pkg::addr_w-1:0] rdata,
  input  logic                         load_en,
  input  logic [fetch_pkg::addr_w-1:0] load_addr,
  input  logic [fetch_pkg::addr_w-1:0] load_data
);
  import fetch_pkg::*;

  logic [addr_w-1:0]     mem [sram_depth];
  logic [sram_idx_w-1:0] rd_idx;
  logic [sram_idx_w-1:0] wr_idx;

  // word index, byte offset and upper bits dropped
  assign rd_idx = addr[sram_idx_w+1:2];
  assign wr_idx = load_addr[sram_idx_w+1:2];

  // read port, output held while en is low
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[rd_idx];
    end
  end

  // load port for program download
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[wr_idx] <= load_data;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_fetch -f flist.f -o tb_fetch
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_fetch > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$log"; then
  exit 0
else
  echo "pass message not found in $log"
  exit 1
fi

// ==== sim/tb_fetch_tasks.svh ====
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

// background word that never decodes as b or bl
function automatic logic [addr_w-1:0] fill_word(input logic [addr_w-1:0] addr);
  logic [addr_w-1:0] w;
  w = addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  w[31:26] = 6'h03;
  return w;
endfunction

// b or bl from one word index to another
function automatic logic [addr_w-1:0] jump_word(input logic [5:0] op, input int from_idx,
                                                input int to_idx);
  logic [25:0] offs;
  offs = 26'(to_idx - from_idx);
  return {op, offs[15:0], offs[25:16]};
endfunction

function automatic ds_out_t expected_out(input logic [addr_w-1:0] pc);
  ds_out_t           e;
  logic [addr_w-1:0] w;
  logic [5:0]        op;
  w = prog[pc[sram_idx_w+1:2]];
  op = w[31:26];
  e.pc = pc;
  e.inst = w;
  e.exc.adef = pc[1] | pc[0];
  e.exc.bad_addr = pc;
  e.is_branch = ~e.exc.adef & ((op == op_b) | (op == op_bl));
  e.link = e.is_branch & (op == op_bl);
  e.rd = e.link ? 5'd1 : w[4:0];
  return e;
endfunction

// pc + 4 or the jump target
function automatic logic [addr_w-1:0] next_model_pc(input ds_out_t e);
  logic [addr_w-1:0] w;
  logic [25:0]       offs;
  w = e.inst;
  offs = {w[9:0], w[25:10]};
  if (e.is_branch) begin
    return e.pc + {{4{offs[25]}}, offs, 2'b00};
  end
  return e.pc + 32'd4;
endfunction

task automatic compare_word(input string what, input logic [addr_w-1:0] exp,
                            input logic [addr_w-1:0] act);
  if (exp !== act) begin
    $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
    fail_run("word mismatch");
  end
endtask

task automatic compare_out(input ds_out_t exp, input ds_out_t act);
  if (exp !== act) begin
    $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
    fail_run("decode output mismatch");
  end
endtask

task automatic fill_memory();
  for (int i = 0; i < sram_depth; i++) begin
    prog[i] = fill_word(base_pc + 32'(i * 4));
  end
endtask

// whole image written while the front end sits in reset
task automatic load_program();
  @(posedge clk);
  resetn     <= 1'b0;
  wb_ex      <= 1'b0;
  ertn_flush <= 1'b0;
  es_allowin <= 1'b1;
  for (int i = 0; i < sram_depth; i++) begin
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= base_pc + 32'(i * 4);
    load_data <= prog[i];
  end
  @(posedge clk);
  load_en <= 1'b0;
  repeat (reset_cycles - 1) @(posedge clk);
  @(negedge clk);
  compare_word("ds_valid in reset", '0, {31'b0, ds_valid});
  @(posedge clk);
  resetn <= 1'b1;
  model_pc = base_pc;
endtask

// drive one cycle on the rising edge and sample the output at the falling edge
task automatic step(input logic stall, input logic ex, input logic ertn,
                    input logic [addr_w-1:0] ex_pc, input logic [addr_w-1:0] ertn_pc,
                    output logic got, output ds_out_t item);
  logic allow;
  allow = 1'b1;
  if (stall) begin
    take_bit(allow);
  end
  @(posedge clk);
  wb_ex          <= ex;
  ertn_flush     <= ertn;
  csr_ex_entry   <= ex_pc;
  csr_ertn_entry <= ertn_pc;
  es_allowin     <= allow;
  @(negedge clk);
  got = ds_valid & es_allowin;
  item = ds_out;
endtask

// accepted output against the model, then the model moves on
task automatic check_item(input ds_out_t item);
  ds_out_t exp;
  exp = expected_out(model_pc);
  compare_out(exp, item);
  model_pc = next_model_pc(exp);
endtask

task automatic run_items(input int n, input logic stall, input logic check_first,
                         input logic [addr_w-1:0] first_pc);
  int      got_cnt;
  logic    got;
  ds_out_t item;
  got_cnt = 0;
  while (got_cnt < n) begin
    step(stall, 1'b0, 1'b0, '0, '0, got, item);
    if (got) begin
      if (check_first && got_cnt == 0) begin
        compare_word("first pc after redirect", first_pc, item.pc);
      end
      check_item(item);
      got_cnt++;
    end
  end
endtask

task automatic pulse(input logic ex, input logic ertn, input logic [addr_w-1:0] ex_pc,
                     input logic [addr_w-1:0] ertn_pc);
  logic    got;
  ds_out_t item;
  step(1'b0, ex, ertn, ex_pc, ertn_pc, got, item);
  if (got) begin
    check_item(item);
  end
  // exception entry wins over return entry
  if (ex) begin
    model_pc = ex_pc;
  end else if (ertn) begin
    model_pc = ertn_pc;
  end
endtask

task automatic test_sequential();
  test_name = "sequential";
  fill_memory();
  load_program();
  run_items(n_seq, 1'b0, 1'b0, '0);
endtask

task automatic test_back_pressure();
  test_name = "back_pressure";
  fill_memory();
  load_program();
  run_items(n_seq, 1'b1, 1'b0, '0);
endtask

// path 0 1 2 -> 8 9 -> 4 5 -> 13 onward
task automatic test_branches();
  test_name = "branches";
  fill_memory();
  prog[2] = jump_word(op_b, 2, 8);
  prog[9] = jump_word(op_b, 9, 4);
  prog[5] = jump_word(op_bl, 5, 13);
  load_program();
  run_items(n_br, 1'b0, 1'b0, '0);
endtask

task automatic test_redirects();
  test_name = "redirects";
  fill_memory();
  load_program();
  run_items(n_red, 1'b0, 1'b0, '0);
  pulse(1'b1, 1'b0, 32'h1c000100, '0);
  run_items(n_red, 1'b0, 1'b1, 32'h1c000100);
  pulse(1'b0, 1'b1, '0, 32'h1c000200);
  run_items(n_red, 1'b0, 1'b1, 32'h1c000200);
  pulse(1'b1, 1'b1, 32'h1c000300, 32'h1c000080);
  run_items(n_red, 1'b0, 1'b1, 32'h1c000300);
endtask

// jump words at the misaligned entry must not decode as branches
task automatic test_address_error();
  test_name = "address_error";
  fill_memory();
  prog[16] = jump_word(op_b, 16, 40);
  prog[17] = jump_word(op_bl, 17, 3);
  load_program();
  run_items(n_red, 1'b0, 1'b0, '0);
  pulse(1'b1, 1'b0, 32'h1c000042, '0);
  run_items(n_adef, 1'b0, 1'b1, 32'h1c000042);
endtask

`endif

// ==== sim/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;
  import fetch_pkg::*;

  // expected outputs of each test
  localparam int n_seq  = 24;
  localparam int n_br   = 12;
  localparam int n_red  = 4;
  localparam int n_adef = 6;

  // sequential, back-pressure, branches, four redirect runs, adef lead-in and tail
  localparam int total_items    = 2 * n_seq + n_br + 5 * n_red + n_adef;
  localparam int timeout_cycles = total_items * 20;
  localparam int reset_cycles   = 16;

  localparam logic [addr_w-1:0] base_pc = 32'h1c000000;

  logic              clk = 1'b0;
  logic              resetn;
  logic              load_en;
  logic [addr_w-1:0] load_addr;
  logic [addr_w-1:0] load_data;
  logic              wb_ex;
  logic              ertn_flush;
  logic [addr_w-1:0] csr_ex_entry;
  logic [addr_w-1:0] csr_ertn_entry;
  ds_out_t           ds_out;
  logic              ds_valid;
  logic              es_allowin;

  // memory image as loaded and the pc the model expects next
  logic [addr_w-1:0] prog [sram_depth];
  logic [addr_w-1:0] model_pc;
  logic [31:0]       lfsr_state = 32'hc43f_e74e;
  int                cycle_cnt = 0;
  string             test_name = "reset";

  fetch_top dut (
    .clk            (clk),
    .resetn         (resetn),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .wb_ex          (wb_ex),
    .ertn_flush     (ertn_flush),
    .csr_ex_entry   (csr_ex_entry),
    .csr_ertn_entry (csr_ertn_entry),
    .ds_out         (ds_out),
    .ds_valid       (ds_valid),
    .es_allowin     (es_allowin)
  );

  always #20 clk = ~clk;

  // galois step with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic fail_run(input string why);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", why);
  endtask

  `include "tb_fetch_tasks.svh"

  // only cycles out of reset count toward the limit
  always @(posedge clk) begin
    if (resetn) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_cycles) begin
        fail_run("timeout: the front end stopped delivering outputs");
      end
    end
  end

  initial begin
    resetn         <= 1'b0;
    load_en        <= 1'b0;
    load_addr      <= '0;
    load_data      <= '0;
    wb_ex          <= 1'b0;
    ertn_flush     <= 1'b0;
    csr_ex_entry   <= '0;
    csr_ertn_entry <= '0;
    es_allowin     <= 1'b1;
    test_sequential();
    test_back_pressure();
    test_branches();
    test_redirects();
    test_address_error();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
